/* hdl/bt_pkg.sv */
`default_nettype none

package bt_pkg;

  // clocks per transmitted bit
  localparam int BIT_CYCLES = 4;

  // access pattern that opens every packet
  localparam logic [7:0] SYNC_WORD = 8'ha7;

  localparam int NUM_CHANNELS = 37;
  localparam int FIFO_DEPTH = 16;

  // occupancy runs from 0 up to FIFO_DEPTH inclusive
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // apb register map, byte offsets
  localparam logic [7:0] ADDR_CTRL = 8'h00;
  localparam logic [7:0] ADDR_HOP = 8'h04;
  localparam logic [7:0] ADDR_TXDATA = 8'h08;
  localparam logic [7:0] ADDR_RXDATA = 8'h0C;
  localparam logic [7:0] ADDR_STATUS = 8'h10;

  typedef logic [5:0] chan_t;

  // register block to datapath
  typedef struct packed {
    logic       tx_start;
    logic       rx_enable;
    logic [5:0] hop_inc;
    logic       chan_load;
    chan_t      chan_init;
    // write-one-to-clear of the sticky overflow flag
    logic       ovf_clear;
  } cfg_t;

  // datapath to register block
  typedef struct packed {
    logic             tx_busy;
    logic [CNT_W-1:0] tx_count;
    logic [CNT_W-1:0] rx_count;
    chan_t            channel;
    logic             rx_overflow;
  } status_t;

  // one received byte, last marks the end of a packet
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } rx_word_t;

endpackage

`default_nettype wire

/* hdl/bt_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module bt_fifo #(
  parameter type payload_t = logic [7:0]
) (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      push,
  input  wire payload_t            wdata,
  input  wire                      pop,
  output payload_t                 rdata,
  output logic                     empty,
  output logic                     full,
  output logic [bt_pkg::CNT_W-1:0] count
);
  import bt_pkg::*;

  localparam int AW = $clog2(FIFO_DEPTH);

  payload_t      mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          do_push;
  logic          do_pop;

  assign do_push = push && !full;
  assign do_pop = pop && !empty;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      wr_ptr <= wr_ptr + AW'(do_push);
      rd_ptr <= rd_ptr + AW'(do_pop);
      count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  // head entry without latency
  assign rdata = mem[rd_ptr];
  assign empty = (count == '0);
  assign full = (count == CNT_W'(FIFO_DEPTH));

  // occupancy and pointer distance agree
  a_count_ptrs: assert property (@(posedge clk) disable iff (rst)
    AW'(count) == AW'(wr_ptr - rd_ptr));
  // a push into a full buffer would overwrite the head
  a_head_stable: assert property (@(posedge clk) disable iff (rst)
    !pop && !empty |=> rdata == $past(rdata));

endmodule

`default_nettype wire

/* hdl/bt_bit_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module bt_bit_timer (
  input  wire  clk,
  input  wire  rst,
  output logic bit_tick
);
  import bt_pkg::*;

  localparam int CW = $clog2(BIT_CYCLES);

  logic [CW-1:0] cnt;

  // free running from reset, tx and rx share this phase
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
    end else if (cnt == CW'(BIT_CYCLES - 1)) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // one clock wide, last cycle of each bit period
  assign bit_tick = (cnt == CW'(BIT_CYCLES - 1));

endmodule

`default_nettype wire

/* hdl/bt_whitener.sv */
`timescale 1ns/1ps
`default_nettype none

module bt_whitener (
  input  wire                clk,
  input  wire                rst,
  input  wire                seed_load,
  input  wire bt_pkg::chan_t seed,
  input  wire                advance,
  output logic               mask
);

  logic [6:0] lfsr;

  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr <= '0;
    end else if (seed_load) begin
      // channel in the low bits, top bit forced so the state is never zero
      lfsr <= {1'b1, seed};
    end else if (advance) begin
      // x^7 + x^4 + 1
      lfsr <= {lfsr[5:0], lfsr[6] ^ lfsr[3]};
    end
  end

  assign mask = lfsr[6];

endmodule

`default_nettype wire

/* hdl/bt_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module bt_apb_regs (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  psel,
  input  wire                  penable,
  input  wire                  pwrite,
  input  wire [7:0]            paddr,
  input  wire [31:0]           pwdata,
  output logic [31:0]          prdata,
  output logic                 pready,
  output logic                 pslverr,
  output bt_pkg::cfg_t         cfg,
  input  wire bt_pkg::status_t status,
  output logic                 tx_push,
  output logic [7:0]           tx_wdata,
  output logic                 rx_pop,
  input  wire bt_pkg::rx_word_t rx_rdata,
  input  wire                  rx_empty
);
  import bt_pkg::*;

  logic       access;
  logic       wr;
  logic       rd;
  logic       sel_ctrl;
  logic       sel_hop;
  logic       sel_tx;
  logic       sel_rx;
  logic       sel_stat;
  logic       mapped;
  logic       rx_en_q;
  logic [5:0] hop_inc_q;

  // access phase of a transfer, always one cycle since pready is tied high
  assign access = psel && penable;
  assign wr = access && pwrite;
  assign rd = access && !pwrite;

  assign sel_ctrl = (paddr == ADDR_CTRL);
  assign sel_hop = (paddr == ADDR_HOP);
  assign sel_tx = (paddr == ADDR_TXDATA);
  assign sel_rx = (paddr == ADDR_RXDATA);
  assign sel_stat = (paddr == ADDR_STATUS);
  assign mapped = sel_ctrl || sel_hop || sel_tx || sel_rx || sel_stat;

  assign pready = 1'b1;
  // data registers are one-directional
  assign pslverr = access && (!mapped || (pwrite && sel_rx) || (!pwrite && sel_tx));

  always_ff @(posedge clk) begin
    if (rst) begin
      rx_en_q <= 1'b0;
      hop_inc_q <= 6'd1;
    end else begin
      if (wr && sel_ctrl) begin
        rx_en_q <= pwdata[1];
      end
      if (wr && sel_hop) begin
        hop_inc_q <= pwdata[5:0];
      end
    end
  end

  always_comb begin
    cfg.tx_start = wr && sel_ctrl && pwdata[0] && !status.tx_busy;
    cfg.rx_enable = rx_en_q;
    cfg.hop_inc = hop_inc_q;
    cfg.chan_load = wr && sel_hop;
    cfg.chan_init = pwdata[13:8];
    cfg.ovf_clear = wr && sel_stat && pwdata[24];
  end

  assign tx_push = wr && sel_tx;
  assign tx_wdata = pwdata[7:0];
  assign rx_pop = rd && sel_rx && !rx_empty;

  always_comb begin
    prdata = '0;
    if (rd) begin
      if (sel_ctrl) begin
        prdata = {30'b0, rx_en_q, status.tx_busy};
      end else if (sel_hop) begin
        prdata = {18'b0, status.channel, 2'b0, hop_inc_q};
      end else if (sel_rx && !rx_empty) begin
        // valid flag above last and data
        prdata = {22'b0, 1'b1, rx_rdata.last, rx_rdata.data};
      end else if (sel_stat) begin
        prdata = {7'b0, status.rx_overflow, status.channel, 1'b0, status.rx_count,
                  3'b0, status.tx_count, 3'b0, status.tx_busy};
      end
    end
  end

  // one pop per read transfer
  a_one_pop_per_read: assert property (@(posedge clk) disable iff (rst)
    rx_pop |=> !rx_pop);

endmodule

`default_nettype wire

/* hdl/bt_tx_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module bt_tx_fsm (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      bit_tick,
  input  wire bt_pkg::cfg_t        cfg,
  input  wire [7:0]                fifo_rdata,
  input  wire                      fifo_empty,
  input  wire [bt_pkg::CNT_W-1:0]  fifo_count,
  output logic                     fifo_pop,
  input  wire                      white_mask,
  output logic                     white_load,
  output logic                     white_advance,
  output logic                     bt_out,
  output logic                     tx_busy,
  output bt_pkg::chan_t            channel
);
  import bt_pkg::*;

  typedef enum logic [2:0] {S_IDLE, S_SYNC, S_LENGTH, S_PAYLOAD, S_HOP} state_t;

  state_t           state;
  logic [7:0]       shreg;
  logic [2:0]       bit_cnt;
  logic [CNT_W-1:0] len;
  logic [CNT_W-1:0] bytes_left;
  logic             accept;
  logic             field_end;
  logic             tx_bit;
  logic [6:0]       hop_sum;
  chan_t            next_chan;

  assign accept = (state == S_IDLE) && cfg.tx_start && !fifo_empty;
  assign field_end = bit_tick && (bit_cnt == 3'd7);
  assign tx_busy = (state != S_IDLE);

  // only payload bits are whitened
  assign tx_bit = (state == S_PAYLOAD) ? (shreg[0] ^ white_mask) : shreg[0];
  assign white_load = accept;
  assign white_advance = bit_tick && (state == S_PAYLOAD);

  // the next byte is taken as the last bit of the previous field goes out
  assign fifo_pop = field_end &&
                    ((state == S_LENGTH) ||
                     ((state == S_PAYLOAD) && (bytes_left != CNT_W'(1))));

  // additive hop mod 37, sum stays below 2*37 + 37
  always_comb begin
    hop_sum = {1'b0, channel} + {1'b0, cfg.hop_inc};
    if (hop_sum >= 7'(2 * NUM_CHANNELS)) begin
      next_chan = chan_t'(hop_sum - 7'(2 * NUM_CHANNELS));
    end else if (hop_sum >= 7'(NUM_CHANNELS)) begin
      next_chan = chan_t'(hop_sum - 7'(NUM_CHANNELS));
    end else begin
      next_chan = hop_sum[5:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_IDLE;
      shreg <= '0;
      bit_cnt <= '0;
      len <= '0;
      bytes_left <= '0;
      bt_out <= 1'b0;
    end else if (state == S_IDLE) begin
      if (accept) begin
        state <= S_SYNC;
        shreg <= SYNC_WORD;
        bit_cnt <= '0;
        len <= fifo_count;
        bytes_left <= fifo_count;
      end
    end else if (state == S_HOP) begin
      // end of the last payload bit
      if (bit_tick) begin
        bt_out <= 1'b0;
        state <= S_IDLE;
      end
    end else if (bit_tick) begin
      bt_out <= tx_bit;
      bit_cnt <= bit_cnt + 1'b1;
      shreg <= {1'b0, shreg[7:1]};
      if (field_end) begin
        if (state == S_SYNC) begin
          state <= S_LENGTH;
          shreg <= 8'(len);
        end else if (state == S_LENGTH) begin
          state <= S_PAYLOAD;
          shreg <= fifo_rdata;
        end else begin
          bytes_left <= bytes_left - 1'b1;
          if (bytes_left == CNT_W'(1)) begin
            state <= S_HOP;
          end else begin
            shreg <= fifo_rdata;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      channel <= '0;
    end else if (cfg.chan_load) begin
      channel <= cfg.chan_init;
    end else if ((state == S_HOP) && bit_tick) begin
      channel <= next_chan;
    end
  end

  a_pop_has_data: assert property (@(posedge clk) disable iff (rst)
    fifo_pop |-> !fifo_empty);

endmodule

`default_nettype wire

/* hdl/bt_rx_deframer.sv */
`timescale 1ns/1ps
`default_nettype none

module bt_rx_deframer (
  input  wire                clk,
  input  wire                rst,
  input  wire                bit_tick,
  input  wire                bt_in,
  input  wire                rx_enable,
  input  wire bt_pkg::chan_t channel,
  input  wire                white_mask,
  output logic               white_load,
  output logic               white_advance,
  output bt_pkg::chan_t      white_seed,
  output logic               push,
  output bt_pkg::rx_word_t   word
);
  import bt_pkg::*;

  typedef enum logic [1:0] {S_SEARCH, S_LENGTH, S_PAYLOAD} state_t;

  state_t     state;
  logic [7:0] shreg;
  logic [2:0] bit_cnt;
  logic [7:0] bytes_left;
  logic       rx_bit;
  logic [7:0] next_byte;
  logic       sync_hit;

  // de-whiten payload bits only
  assign rx_bit = (state == S_PAYLOAD) ? (bt_in ^ white_mask) : bt_in;
  // lsb first, so new bits enter at the top
  assign next_byte = {rx_bit, shreg[7:1]};
  assign sync_hit = bit_tick && rx_enable && (state == S_SEARCH) &&
                    (next_byte == SYNC_WORD);

  // whitener seeded with the channel current at sync
  assign white_load = sync_hit;
  assign white_seed = channel;
  assign white_advance = bit_tick && (state == S_PAYLOAD);

  assign push = white_advance && (bit_cnt == 3'd7);

  always_comb begin
    word.data = next_byte;
    word.last = (bytes_left == 8'd1);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_SEARCH;
      shreg <= '0;
      bit_cnt <= '0;
      bytes_left <= '0;
    end else if (bit_tick) begin
      shreg <= next_byte;
      case (state)
        S_SEARCH: begin
          if (sync_hit) begin
            state <= S_LENGTH;
            bit_cnt <= '0;
          end
        end
        S_LENGTH: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == 3'd7) begin
            bytes_left <= next_byte;
            if (next_byte == 8'd0) begin
              state <= S_SEARCH;
              shreg <= '0;
            end else begin
              state <= S_PAYLOAD;
            end
          end
        end
        default: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == 3'd7) begin
            bytes_left <= bytes_left - 1'b1;
            // back to hunting, old payload bits must not fake a sync
            if (bytes_left == 8'd1) begin
              state <= S_SEARCH;
              shreg <= '0;
            end
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/bt_top.sv */
`timescale 1ns/1ps
`default_nettype none

module bt_top (
  input  wire           clk,
  input  wire           rst,
  input  wire           psel,
  input  wire           penable,
  input  wire           pwrite,
  input  wire [7:0]     paddr,
  input  wire [31:0]    pwdata,
  output logic [31:0]   prdata,
  output logic          pready,
  output logic          pslverr,
  output logic          bt_out,
  input  wire           bt_in,
  output bt_pkg::chan_t channel,
  output logic          irq
);
  import bt_pkg::*;

  cfg_t             cfg;
  status_t          status;
  logic             bit_tick;
  logic             tx_push;
  logic [7:0]       tx_wdata;
  logic [7:0]       tx_rdata;
  logic             tx_pop;
  logic             tx_empty;
  logic [CNT_W-1:0] tx_count;
  logic             tx_busy;
  logic             tx_mask;
  logic             tx_wload;
  logic             tx_wadv;
  logic             rx_push;
  logic             rx_pop;
  logic             rx_empty;
  logic             rx_full;
  rx_word_t         rx_wword;
  rx_word_t         rx_rword;
  logic [CNT_W-1:0] rx_count;
  logic             rx_mask;
  logic             rx_wload;
  logic             rx_wadv;
  chan_t            rx_seed;
  logic             rx_overflow;

  bt_apb_regs i_regs (
    .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .cfg, .status, .tx_push, .tx_wdata, .rx_pop, .rx_rdata(rx_rword), .rx_empty
  );

  bt_bit_timer i_timer (.clk, .rst, .bit_tick);

  bt_fifo #(.payload_t(logic [7:0])) i_tx_fifo (
    .clk, .rst, .push(tx_push), .wdata(tx_wdata), .pop(tx_pop), .rdata(tx_rdata),
    .empty(tx_empty), .full(), .count(tx_count)
  );

  bt_fifo #(.payload_t(rx_word_t)) i_rx_fifo (
    .clk, .rst, .push(rx_push), .wdata(rx_wword), .pop(rx_pop), .rdata(rx_rword),
    .empty(rx_empty), .full(rx_full), .count(rx_count)
  );

  bt_whitener i_tx_white (
    .clk, .rst, .seed_load(tx_wload), .seed(channel), .advance(tx_wadv), .mask(tx_mask)
  );

  bt_whitener i_rx_white (
    .clk, .rst, .seed_load(rx_wload), .seed(rx_seed), .advance(rx_wadv), .mask(rx_mask)
  );

  bt_tx_fsm i_tx (
    .clk, .rst, .bit_tick, .cfg, .fifo_rdata(tx_rdata), .fifo_empty(tx_empty),
    .fifo_count(tx_count), .fifo_pop(tx_pop), .white_mask(tx_mask), .white_load(tx_wload),
    .white_advance(tx_wadv), .bt_out, .tx_busy, .channel
  );

  bt_rx_deframer i_rx (
    .clk, .rst, .bit_tick, .bt_in, .rx_enable(cfg.rx_enable), .channel,
    .white_mask(rx_mask), .white_load(rx_wload), .white_advance(rx_wadv),
    .white_seed(rx_seed), .push(rx_push), .word(rx_wword)
  );

  // sticky until the host clears it, a new drop wins over the clear
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_overflow <= 1'b0;
    end else if (rx_push && rx_full) begin
      rx_overflow <= 1'b1;
    end else if (cfg.ovf_clear) begin
      rx_overflow <= 1'b0;
    end
  end

  always_comb begin
    status.tx_busy = tx_busy;
    status.tx_count = tx_count;
    status.rx_count = rx_count;
    status.channel = channel;
    status.rx_overflow = rx_overflow;
  end

  assign irq = !rx_empty;

endmodule

`default_nettype wire

/* testbench/tb_bt.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_bt;
  import bt_pkg::*;

  localparam int HALF_PERIOD = 20;
  localparam int DRIVE_DELAY = 2;
  localparam int RESET_CYCLES = 4;
  localparam int HOP_PACKETS = 3;
  localparam int RAND_PACKETS = 6;
  localparam int NUM_PACKETS = 1 + HOP_PACKETS + RAND_PACKETS + 2;
  localparam int PACKET_BITS_MAX = 16 + 8 * FIFO_DEPTH;
  localparam int APB_CYCLES_PER_PACKET = 3 * (2 * FIFO_DEPTH + 30);
  localparam int WATCHDOG_CYCLES =
    2 * NUM_PACKETS * ((PACKET_BITS_MAX + 2) * BIT_CYCLES + APB_CYCLES_PER_PACKET);
  localparam int MAX_POLLS = 20;

  logic        clk = 1'b0;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        bt_out;
  logic        bt_in;
  chan_t       channel;
  logic        irq;

  logic        last_err;
  logic [31:0] rng_state = 32'hd6b6aefa;
  chan_t       exp_chan;
  logic [5:0]  hop_inc;
  logic        exp_bits[$];
  logic        got_bits[$];

  always #HALF_PERIOD clk = ~clk;

  // loopback radio
  assign bt_in = bt_out;

  bt_top i_bt_top (
    .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .bt_out, .bt_in, .channel, .irq
  );

  task automatic end_in_failure();
    $display("tests failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      end_in_failure();
    end
  endtask

  // galois form, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        b;
    v = '0;
    for (int i = 0; i < n; i++) begin
      b = rng_state[0];
      rng_state = rng_state >> 1;
      if (b) begin
        rng_state = rng_state ^ 32'h80200003;
      end
      v = {v[30:0], b};
    end
    return v;
  endfunction

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(posedge clk);
    #DRIVE_DELAY;
    penable = 1'b1;
    @(negedge clk);
    last_err = pslverr;
    check("pready", 32'(pready), 32'd1);
    @(posedge clk);
    #DRIVE_DELAY;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = addr;
    @(posedge clk);
    #DRIVE_DELAY;
    penable = 1'b1;
    @(negedge clk);
    data = prdata;
    last_err = pslverr;
    check("pready", 32'(pready), 32'd1);
    @(posedge clk);
    #DRIVE_DELAY;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  // sync, length, whitened payload, all lsb first
  task automatic build_expected(input chan_t ch, input logic [7:0] bytes[$]);
    logic [6:0] seed;
    logic [7:0] len;
    logic       mask[$];
    exp_bits.delete();
    len = 8'(bytes.size());
    for (int i = 0; i < 8; i++) begin
      exp_bits.push_back(SYNC_WORD[i]);
    end
    for (int i = 0; i < 8; i++) begin
      exp_bits.push_back(len[i]);
    end
    // x^7 + x^4 sequence, the first seven mask bits are the seed from bit 6 down
    seed = {1'b1, ch};
    for (int i = 6; i >= 0; i--) begin
      mask.push_back(seed[i]);
    end
    for (int n = 7; n < 8 * bytes.size(); n++) begin
      mask.push_back(mask[n - 7] ^ mask[n - 4]);
    end
    foreach (bytes[k]) begin
      for (int j = 0; j < 8; j++) begin
        exp_bits.push_back(bytes[k][j] ^ mask[8 * k + j]);
      end
    end
  endtask

  // first sync bit is a one, then one sample per bit period
  task automatic capture_bits(input int nbits);
    int waited;
    got_bits.delete();
    waited = 0;
    while (bt_out !== 1'b1) begin
      @(posedge clk);
      #DRIVE_DELAY;
      waited++;
      if (waited > 2 * BIT_CYCLES) begin
        $display("no packet started on bt_out after the start command");
        end_in_failure();
      end
    end
    got_bits.push_back(bt_out);
    for (int i = 1; i < nbits; i++) begin
      repeat (BIT_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      got_bits.push_back(bt_out);
    end
  endtask

  task automatic wait_tx_idle(output logic [31:0] st);
    int polls;
    polls = 0;
    apb_read(ADDR_STATUS, st);
    while (st[0]) begin
      polls++;
      if (polls > MAX_POLLS) begin
        $display("transmitter stayed busy after the last packet bit");
        end_in_failure();
      end
      apb_read(ADDR_STATUS, st);
    end
  endtask

  task automatic transmit_packet(input logic [7:0] bytes[$]);
    logic [31:0] st;
    foreach (bytes[k]) begin
      apb_write(ADDR_TXDATA, 32'(bytes[k]));
    end
    apb_read(ADDR_STATUS, st);
    check("status tx_count", 32'(st[8:4]), 32'(bytes.size()));
    build_expected(exp_chan, bytes);
    apb_write(ADDR_CTRL, 32'h3);
    capture_bits(exp_bits.size());
    foreach (exp_bits[i]) begin
      check("bt_out bit", 32'(got_bits[i]), 32'(exp_bits[i]));
    end
    // last bit still on the line, busy until it ends
    apb_read(ADDR_STATUS, st);
    check("status tx_busy", 32'(st[0]), 32'd1);
    wait_tx_idle(st);
    exp_chan = chan_t'((int'(exp_chan) + int'(hop_inc)) % NUM_CHANNELS);
    check("status channel", 32'(st[23:18]), 32'(exp_chan));
    check("channel", 32'(channel), 32'(exp_chan));
  endtask

  task automatic receive_packet(input logic [7:0] bytes[$]);
    logic [31:0] rd;
    check("irq", 32'(irq), 32'd1);
    foreach (bytes[k]) begin
      apb_read(ADDR_RXDATA, rd);
      check("rxdata data", 32'(rd[7:0]), 32'(bytes[k]));
      check("rxdata last", 32'(rd[8]), 32'(k == bytes.size() - 1));
      check("rxdata valid", 32'(rd[9]), 32'd1);
    end
    check("irq", 32'(irq), 32'd0);
    apb_read(ADDR_RXDATA, rd);
    check("rxdata when empty", rd, 32'd0);
  endtask

  task automatic test_reset();
    logic [31:0] st;
    check("bt_out", 32'(bt_out), 32'd0);
    check("irq", 32'(irq), 32'd0);
    check("channel", 32'(channel), 32'd0);
    apb_read(ADDR_STATUS, st);
    check("status", st, 32'd0);
    check("pslverr", 32'(last_err), 32'd0);
  endtask

  task automatic test_known_packet();
    logic [7:0] bytes[$];
    bytes = '{8'h00, 8'hff, 8'h3c, 8'h81};
    apb_write(ADDR_CTRL, 32'h2);
    transmit_packet(bytes);
    receive_packet(bytes);
  endtask

  task automatic test_hop();
    logic [7:0]  bytes[$];
    logic [31:0] st;
    exp_chan = 6'd35;
    hop_inc = 6'd5;
    apb_write(ADDR_HOP, 32'({exp_chan, 2'b00, hop_inc}));
    apb_read(ADDR_STATUS, st);
    check("status channel", 32'(st[23:18]), 32'(exp_chan));
    repeat (HOP_PACKETS) begin
      bytes.delete();
      repeat (2) bytes.push_back(8'(rand_bits(8)));
      transmit_packet(bytes);
      receive_packet(bytes);
    end
  endtask

  task automatic test_random();
    logic [7:0] bytes[$];
    int         len;
    repeat (RAND_PACKETS) begin
      len = 1 + int'(rand_bits(4)) % 15;
      bytes.delete();
      repeat (len) bytes.push_back(8'(rand_bits(8)));
      transmit_packet(bytes);
      receive_packet(bytes);
    end
  endtask

  task automatic test_overflow();
    logic [7:0]  first[$];
    logic [7:0]  second[$];
    logic [31:0] st;
    repeat (FIFO_DEPTH) first.push_back(8'(rand_bits(8)));
    repeat (2) second.push_back(8'(rand_bits(8)));
    transmit_packet(first);
    // exactly full, nothing dropped yet
    apb_read(ADDR_STATUS, st);
    check("status rx_overflow", 32'(st[24]), 32'd0);
    check("status rx_count", 32'(st[16:12]), 32'(FIFO_DEPTH));
    // no reads in between, the second packet finds the rx fifo full
    transmit_packet(second);
    apb_read(ADDR_STATUS, st);
    check("status rx_overflow", 32'(st[24]), 32'd1);
    check("status rx_count", 32'(st[16:12]), 32'(FIFO_DEPTH));
    apb_write(ADDR_STATUS, 32'h0100_0000);
    apb_read(ADDR_STATUS, st);
    check("status rx_overflow", 32'(st[24]), 32'd0);
    receive_packet(first);
  endtask

  task automatic test_slverr();
    logic [31:0] rd;
    apb_read(8'h14, rd);
    check("pslverr unmapped read", 32'(last_err), 32'd1);
    apb_write(8'h20, 32'h1);
    check("pslverr unmapped write", 32'(last_err), 32'd1);
    apb_write(ADDR_RXDATA, 32'h55);
    check("pslverr rxdata write", 32'(last_err), 32'd1);
    apb_read(ADDR_TXDATA, rd);
    check("pslverr txdata read", 32'(last_err), 32'd1);
    apb_read(ADDR_STATUS, rd);
    check("pslverr status read", 32'(last_err), 32'd0);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired before the tests finished");
    end_in_failure();
  end

  initial begin
    rst = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    last_err = 1'b0;
    exp_chan = '0;
    hop_inc = 6'd1;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;
    test_reset();
    test_known_packet();
    test_hop();
    test_random();
    test_overflow();
    test_slverr();
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
hdl/bt_pkg.sv
hdl/bt_fifo.sv
hdl/bt_bit_timer.sv
hdl/bt_whitener.sv
hdl/bt_apb_regs.sv
hdl/bt_tx_fsm.sv
hdl/bt_rx_deframer.sv
hdl/bt_top.sv
testbench/tb_bt.sv

/* run.sh */
#!/bin/sh
# build and run the loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_bt \
  --Mdir obj_dir -o tb_bt
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_bt > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
  echo "simulation FAILED"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi
echo "simulation passed"
exit 0
